/* hw/rdp_consts.svh */
// *******************************************************************
// Read datapath constants
// Fixed widths, FIFO depths and termination delays of the read path
// *******************************************************************
`ifndef RDP_CONSTS_SVH
`define RDP_CONSTS_SVH

// Two DQS groups of eight DQ bits make up one AFI read word
`define RDP_DQS_GROUPS 2
`define RDP_GROUP_WIDTH 8
`define RDP_DQ_WIDTH 16

// Length of the read-enable shifter and the width of the latency count
`define RDP_MAX_READ_LATENCY 16
`define RDP_LAT_WIDTH 4

// Each group FIFO holds eight bytes
`define RDP_FIFO_DEPTH 8
`define RDP_FIFO_AW 3

// Termination window, in AFI cycles of read-enable history
`define RDP_OCT_ON_DELAY 1
`define RDP_OCT_OFF_DELAY 4

`endif

/* hw/rdp_pkg.sv */
// *******************************************************************
// Read datapath types
// Vector types shared by the read-return path and its testbench
// *******************************************************************
`default_nettype none
`include "rdp_consts.svh"

package rdp_pkg;

	// Full AFI read word and a single group's slice of it
	typedef logic [`RDP_DQ_WIDTH-1:0] rdp_dq_t;
	typedef logic [`RDP_GROUP_WIDTH-1:0] rdp_group_dq_t;

	// One bit per DQS group, used for capture strobes and FIFO flags
	typedef logic [`RDP_DQS_GROUPS-1:0] rdp_group_mask_t;

	// Read latency programmed by the sequencer
	typedef logic [`RDP_LAT_WIDTH-1:0] rdp_lat_t;

	// The extra top bit tells a full FIFO from an empty one
	typedef logic [`RDP_FIFO_AW:0] rdp_fifo_ptr_t;

endpackage

`default_nettype wire

/* hw/rdp_latency_fifo.sv */
// *******************************************************************
// Latency FIFO
// Delays the AFI read-enable by the sequencer latency to pop read data
// *******************************************************************
`timescale 1ns/10ps
`default_nettype none
`include "rdp_consts.svh"

module rdp_latency_fifo (
	input  logic              pll_afi_clk,
	input  logic              reset_n_afi_clk,
	input  logic              afi_rdata_en_i,
	input  rdp_pkg::rdp_lat_t seq_read_latency_i,
	output logic              read_pop_o
);

	// Bit k holds the read-enable seen k+1 edges ago
	logic [`RDP_MAX_READ_LATENCY-1:0] lat_shifter;

	// Tap select, so that a latency of L reads the enable from L edges back
	rdp_pkg::rdp_lat_t tap_sel;

	assign tap_sel = seq_read_latency_i - rdp_pkg::rdp_lat_t'(1);

	// *******************************************************************
	// Shifter and registered tap
	// *******************************************************************

	// Every enable walks the shifter on its own, so any number of reads
	// can be in flight at once
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			lat_shifter <= '0;
			read_pop_o  <= 1'b0;
		end else begin
			lat_shifter <= {lat_shifter[`RDP_MAX_READ_LATENCY-2:0], afi_rdata_en_i};
			// An enable sampled at edge t is popped in the cycle after edge t+L
			read_pop_o  <= lat_shifter[tap_sel];
		end
	end

	// A zero latency would wrap the tap select onto the oldest stage, so the
	// sequencer must hold a legal value while any read is on its way
	a_latency_nonzero: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(afi_rdata_en_i || (|lat_shifter)) |-> (seq_read_latency_i != '0)
	) else $error("read latency is zero with reads in flight");

endmodule

`default_nettype wire

/* hw/rdp_oct_ctrl.sv */
// *******************************************************************
// Termination control
// Forces on-die termination off outside the window around read data
// *******************************************************************
`timescale 1ns/10ps
`default_nettype none
`include "rdp_consts.svh"

module rdp_oct_ctrl (
	input  logic pll_afi_clk,
	input  logic reset_n_afi_clk,
	input  logic afi_rdata_en_i,
	output logic force_oct_off_o
);

	// Recent read-enable history, newest in bit 0
	logic [`RDP_OCT_OFF_DELAY-1:0] rdata_en_r;

	// History with the live enable appended at the bottom
	logic [`RDP_OCT_OFF_DELAY:0] rdata_en_shifter;

	assign rdata_en_shifter = {rdata_en_r, afi_rdata_en_i};

	// Termination stays on while any enable sits between the on and off
	// delays of the history, which covers the returning read burst
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			rdata_en_r      <= '0;
			force_oct_off_o <= 1'b0;
		end else begin
			rdata_en_r      <= rdata_en_shifter[`RDP_OCT_OFF_DELAY-1:0];
			force_oct_off_o <=
				~(|rdata_en_shifter[`RDP_OCT_OFF_DELAY:`RDP_OCT_ON_DELAY]);
		end
	end

	// Every read enable opens the termination window for its returning burst,
	// from the on delay through the off delay after it
	a_oct_window_on: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		afi_rdata_en_i |-> ##(`RDP_OCT_ON_DELAY + 1)
			(!force_oct_off_o) [*(`RDP_OCT_OFF_DELAY - `RDP_OCT_ON_DELAY + 1)]
	) else $error("termination not enabled after a read enable");

endmodule

`default_nettype wire

/* hw/rdp_read_fifo.sv */
// *******************************************************************
// Read data FIFO
// One byte FIFO per DQS group, popped together into one AFI word
// *******************************************************************
`timescale 1ns/10ps
`default_nettype none
`include "rdp_consts.svh"

module rdp_read_fifo (
	input  logic                     pll_afi_clk,
	input  logic                     reset_n_afi_clk,
	input  logic                     seq_read_fifo_reset_i,
	input  rdp_pkg::rdp_dq_t         capture_dq_i,
	input  rdp_pkg::rdp_group_mask_t capture_valid_i,
	input  logic                     read_pop_i,
	output rdp_pkg::rdp_dq_t         fifo_dq_o,
	output logic                     fifo_dq_valid_o,
	output logic                     fifo_underrun_o
);

	// Per-group status flags
	rdp_pkg::rdp_group_mask_t grp_empty;
	rdp_pkg::rdp_group_mask_t grp_full;

	// *******************************************************************
	// Group FIFOs
	// *******************************************************************

	for (genvar g = 0; g < `RDP_DQS_GROUPS; g++) begin : g_group
		rdp_pkg::rdp_group_dq_t mem [`RDP_FIFO_DEPTH];
		rdp_pkg::rdp_fifo_ptr_t wr_ptr;
		rdp_pkg::rdp_fifo_ptr_t rd_ptr;
		rdp_pkg::rdp_group_dq_t rd_data;
		logic                   wr_en;
		logic                   rd_en;

		// Equal pointers mean empty; equal addresses with opposite wrap bits mean full
		assign grp_empty[g] = (wr_ptr == rd_ptr);
		assign grp_full[g]  = (wr_ptr[`RDP_FIFO_AW] != rd_ptr[`RDP_FIFO_AW]) &&
			(wr_ptr[`RDP_FIFO_AW-1:0] == rd_ptr[`RDP_FIFO_AW-1:0]);

		// Writes into a full group are dropped, and a FIFO reset wins
		// over both sides
		assign wr_en = capture_valid_i[g] && !grp_full[g] && !seq_read_fifo_reset_i;
		assign rd_en = read_pop_i && !grp_empty[g] && !seq_read_fifo_reset_i;

		always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
			if (!reset_n_afi_clk) begin
				wr_ptr <= '0;
				rd_ptr <= '0;
			end else if (seq_read_fifo_reset_i) begin
				wr_ptr <= '0;
				rd_ptr <= '0;
			end else begin
				if (wr_en) begin
					wr_ptr <= wr_ptr + rdp_pkg::rdp_fifo_ptr_t'(1);
				end
				if (rd_en) begin
					rd_ptr <= rd_ptr + rdp_pkg::rdp_fifo_ptr_t'(1);
				end
			end
		end

		// Storage and the registered read port
		// An empty group keeps its last byte, which the underrun flag marks
		always_ff @(posedge pll_afi_clk) begin
			if (wr_en) begin
				mem[wr_ptr[`RDP_FIFO_AW-1:0]] <=
					capture_dq_i[g*`RDP_GROUP_WIDTH +: `RDP_GROUP_WIDTH];
			end
			if (rd_en) begin
				rd_data <= mem[rd_ptr[`RDP_FIFO_AW-1:0]];
			end
		end

		// Group g lands in bits 8g+7 down to 8g of the AFI word
		assign fifo_dq_o[g*`RDP_GROUP_WIDTH +: `RDP_GROUP_WIDTH] = rd_data;

		// The capture side has no back-pressure, so a full group loses data
		a_no_write_full: assert property (
			@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
			(capture_valid_i[g] && !seq_read_fifo_reset_i) |-> !grp_full[g]
		) else $error("capture write into full group %0d", g);
	end

	// *******************************************************************
	// Pop status
	// *******************************************************************

	// Valid and underrun line up with the data one cycle after the pop
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			fifo_dq_valid_o <= 1'b0;
			fifo_underrun_o <= 1'b0;
		end else begin
			fifo_dq_valid_o <= read_pop_i && !seq_read_fifo_reset_i;
			fifo_underrun_o <= read_pop_i && !seq_read_fifo_reset_i && (|grp_empty);
		end
	end

endmodule

`default_nettype wire

/* hw/rdp_rdata_output.sv */
// *******************************************************************
// Read data output stage
// Registers the AFI read word and valid and keeps the underflow flag
// *******************************************************************
`timescale 1ns/10ps
`default_nettype none

module rdp_rdata_output (
	input  logic             pll_afi_clk,
	input  logic             reset_n_afi_clk,
	input  logic             seq_read_fifo_reset_i,
	input  rdp_pkg::rdp_dq_t fifo_dq_i,
	input  logic             fifo_dq_valid_i,
	input  logic             fifo_underrun_i,
	output rdp_pkg::rdp_dq_t afi_rdata_o,
	output logic             afi_rdata_valid_o,
	output logic             rdata_underflow_o
);

	// Data only loads with a valid word and is qualified by the valid output
	always_ff @(posedge pll_afi_clk) begin
		if (fifo_dq_valid_i) begin
			afi_rdata_o <= fifo_dq_i;
		end
	end

	// Valid pulse toward the controller
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			afi_rdata_valid_o <= 1'b0;
		end else begin
			afi_rdata_valid_o <= fifo_dq_valid_i;
		end
	end

	// Sticky underflow, set by any pop that found a group empty
	// and held until the sequencer resets the FIFOs
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			rdata_underflow_o <= 1'b0;
		end else if (seq_read_fifo_reset_i) begin
			rdata_underflow_o <= 1'b0;
		end else if (fifo_dq_valid_i && fifo_underrun_i) begin
			rdata_underflow_o <= 1'b1;
		end
	end

	// A valid edge toward the AFI always comes from a FIFO pop one cycle back
	a_valid_follows_fifo: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		$rose(afi_rdata_valid_o) |-> $past(fifo_dq_valid_i)
	) else $error("read valid rose without FIFO valid");

endmodule

`default_nettype wire

/* hw/rdp_read_datapath.sv */
// *******************************************************************
// Read datapath top
// Latency FIFO, termination control, group FIFOs and AFI output stage
// *******************************************************************
`timescale 1ns/10ps
`default_nettype none

module rdp_read_datapath (
	input  logic                     pll_afi_clk,
	input  logic                     reset_n_afi_clk,
	input  logic                     afi_rdata_en_i,
	input  rdp_pkg::rdp_lat_t        seq_read_latency_i,
	input  rdp_pkg::rdp_dq_t         capture_dq_i,
	input  rdp_pkg::rdp_group_mask_t capture_valid_i,
	input  logic                     seq_read_fifo_reset_i,
	output rdp_pkg::rdp_dq_t         afi_rdata_o,
	output logic                     afi_rdata_valid_o,
	output logic                     rdata_underflow_o,
	output logic                     force_oct_off_o
);

	// Pop strobe from the latency FIFO to the group FIFOs
	logic             read_pop;

	// Group FIFO word and status toward the output stage
	rdp_pkg::rdp_dq_t fifo_dq;
	logic             fifo_dq_valid;
	logic             fifo_underrun;

	rdp_latency_fifo u_latency_fifo (
		.pll_afi_clk        (pll_afi_clk),
		.reset_n_afi_clk    (reset_n_afi_clk),
		.afi_rdata_en_i     (afi_rdata_en_i),
		.seq_read_latency_i (seq_read_latency_i),
		.read_pop_o         (read_pop)
	);

	// Termination runs straight from the controller enable
	rdp_oct_ctrl u_oct_ctrl (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.afi_rdata_en_i  (afi_rdata_en_i),
		.force_oct_off_o (force_oct_off_o)
	);

	rdp_read_fifo u_read_fifo (
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.seq_read_fifo_reset_i (seq_read_fifo_reset_i),
		.capture_dq_i          (capture_dq_i),
		.capture_valid_i       (capture_valid_i),
		.read_pop_i            (read_pop),
		.fifo_dq_o             (fifo_dq),
		.fifo_dq_valid_o       (fifo_dq_valid),
		.fifo_underrun_o       (fifo_underrun)
	);

	rdp_rdata_output u_rdata_output (
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.seq_read_fifo_reset_i (seq_read_fifo_reset_i),
		.fifo_dq_i             (fifo_dq),
		.fifo_dq_valid_i       (fifo_dq_valid),
		.fifo_underrun_i       (fifo_underrun),
		.afi_rdata_o           (afi_rdata_o),
		.afi_rdata_valid_o     (afi_rdata_valid_o),
		.rdata_underflow_o     (rdata_underflow_o)
	);

endmodule

`default_nettype wire

/* verif/rdp_checker.sv */
// *******************************************************************
// Read datapath checker
// Reference model of read timing, byte order, termination and underflow
// *******************************************************************
`timescale 1ns/10ps
`default_nettype none
`include "rdp_consts.svh"

module rdp_checker (
	input  logic                     pll_afi_clk,
	input  logic                     reset_n_afi_clk,
	input  logic                     afi_rdata_en_i,
	input  rdp_pkg::rdp_lat_t        seq_read_latency_i,
	input  rdp_pkg::rdp_dq_t         capture_dq_i,
	input  rdp_pkg::rdp_group_mask_t capture_valid_i,
	input  logic                     seq_read_fifo_reset_i,
	input  rdp_pkg::rdp_dq_t         afi_rdata_i,
	input  logic                     afi_rdata_valid_i,
	input  logic                     rdata_underflow_i,
	input  logic                     force_oct_off_i,
	output int                       tests_passed_o,
	output int                       tests_failed_o
);

	// Edge count, and the edge on which each outstanding read must show valid
	int                     cyc = 0;
	int                     valid_due[$];
	// Bytes captured per group since the last FIFO reset
	rdp_pkg::rdp_group_dq_t bytes0_q[$];
	rdp_pkg::rdp_group_dq_t bytes1_q[$];
	// Bit i holds the enable sampled i+1 edges ago
	logic [`RDP_OCT_OFF_DELAY:0] en_hist = '0;
	logic                   exp_uflow = 1'b0;
	logic                   out_of_reset = 1'b0;
	string                  test_name = "idle";
	int                     test_errs = 0;
	int                     passed_cnt = 0;
	int                     failed_cnt = 0;

	assign tests_passed_o = passed_cnt;
	assign tests_failed_o = failed_cnt;

	task automatic begin_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		// Reads still outstanding at the end of a test never returned
		while (valid_due.size() > 0) begin
			$display("%s: valid pulse missing, due at cycle %0d", test_name, valid_due.pop_front());
			test_errs++;
		end
		if (test_errs == 0) begin
			passed_cnt++;
			$display("test %s passed", test_name);
		end else begin
			failed_cnt++;
			$display("test %s failed with %0d errors", test_name, test_errs);
		end
	endtask

	task automatic check_value(input string what, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp) begin
			$display("error %s %s expected %h actual %h", test_name, what, exp, act);
			test_errs++;
		end
	endtask

	// Termination is on when some enable lies k edges back, with k from
	// one past the on delay through one past the off delay
	function automatic logic oct_off_expected();
		logic off;
		off = 1'b1;
		for (int k = `RDP_OCT_ON_DELAY + 1; k <= `RDP_OCT_OFF_DELAY + 1; k++) begin
			if (en_hist[k - 1]) begin
				off = 1'b0;
			end
		end
		return off;
	endfunction

	// Each valid word takes the head byte of every group that has one
	// and an empty group means the pop underflowed
	task automatic pop_word();
		if (bytes0_q.size() == 0 || bytes1_q.size() == 0) begin
			exp_uflow = 1'b1;
		end
		if (bytes0_q.size() > 0) begin
			check_value("group0 data", bytes0_q.pop_front(), afi_rdata_i[`RDP_GROUP_WIDTH-1:0]);
		end
		if (bytes1_q.size() > 0) begin
			check_value("group1 data", bytes1_q.pop_front(),
				afi_rdata_i[`RDP_DQ_WIDTH-1:`RDP_GROUP_WIDTH]);
		end
	endtask

	// *******************************************************************
	// Compare on every edge, then fold in the inputs sampled there
	// *******************************************************************
	always @(posedge pll_afi_clk) begin
		cyc++;
		if (!reset_n_afi_clk) begin
			out_of_reset = 1'b0;
			en_hist = '0;
			exp_uflow = 1'b0;
			valid_due.delete();
			bytes0_q.delete();
			bytes1_q.delete();
		end else if (!out_of_reset) begin
			// The first edge after reset still shows the reset values
			check_value("afi_rdata_valid", 0, afi_rdata_valid_i);
			check_value("rdata_underflow", 0, rdata_underflow_i);
			check_value("force_oct_off", 0, force_oct_off_i);
			out_of_reset = 1'b1;
		end else begin
			while (valid_due.size() > 0 && valid_due[0] < cyc) begin
				$display("%s: valid pulse missing at cycle %0d", test_name, valid_due.pop_front());
				test_errs++;
			end
			if (afi_rdata_valid_i) begin
				if (valid_due.size() == 0 || valid_due[0] != cyc) begin
					$display("%s: unexpected valid pulse at cycle %0d", test_name, cyc);
					test_errs++;
				end else begin
					void'(valid_due.pop_front());
				end
				pop_word();
			end
			check_value("rdata_underflow", exp_uflow, rdata_underflow_i);
			check_value("force_oct_off", oct_off_expected(), force_oct_off_i);
		end
		if (reset_n_afi_clk) begin
			en_hist = {en_hist[`RDP_OCT_OFF_DELAY-1:0], afi_rdata_en_i};
			if (seq_read_fifo_reset_i) begin
				bytes0_q.delete();
				bytes1_q.delete();
				exp_uflow = 1'b0;
			end else begin
				if (capture_valid_i[0]) begin
					bytes0_q.push_back(capture_dq_i[`RDP_GROUP_WIDTH-1:0]);
				end
				if (capture_valid_i[1]) begin
					bytes1_q.push_back(capture_dq_i[`RDP_DQ_WIDTH-1:`RDP_GROUP_WIDTH]);
				end
			end
			// Valid is driven L+2 edges after the enable and seen one edge later
			if (afi_rdata_en_i) begin
				valid_due.push_back(cyc + seq_read_latency_i + 3);
			end
		end
	end

endmodule

`default_nettype wire

/* verif/tb_rdp.sv */
// *******************************************************************
// Read datapath testbench
// Seeded random reads and captures through the DUT, scored by the checker
// *******************************************************************
`timescale 1ns/10ps
`default_nettype none
`include "rdp_consts.svh"

module tb_rdp;

	localparam int CLK_PERIOD = 40;
	// Worst-case cycle counts of each test, summed for the watchdog
	localparam int LAT_READS = 10;
	localparam int LAT_CYC = LAT_READS * 5 + 20;
	localparam int BATCH_CYC = 60;
	localparam int BUDGET_CYC = 10 + 3 * LAT_CYC + 8 * BATCH_CYC + 60 + 120 + 100;

	logic                     pll_afi_clk;
	logic                     reset_n_afi_clk;
	logic                     afi_rdata_en_i;
	rdp_pkg::rdp_lat_t        seq_read_latency_i;
	rdp_pkg::rdp_dq_t         capture_dq_i;
	rdp_pkg::rdp_group_mask_t capture_valid_i;
	logic                     seq_read_fifo_reset_i;
	rdp_pkg::rdp_dq_t         afi_rdata_o;
	logic                     afi_rdata_valid_o;
	logic                     rdata_underflow_o;
	logic                     force_oct_off_o;
	int                       tests_passed;
	int                       tests_failed;
	int                       seed;

	rdp_read_datapath dut_i (
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.afi_rdata_en_i        (afi_rdata_en_i),
		.seq_read_latency_i    (seq_read_latency_i),
		.capture_dq_i          (capture_dq_i),
		.capture_valid_i       (capture_valid_i),
		.seq_read_fifo_reset_i (seq_read_fifo_reset_i),
		.afi_rdata_o           (afi_rdata_o),
		.afi_rdata_valid_o     (afi_rdata_valid_o),
		.rdata_underflow_o     (rdata_underflow_o),
		.force_oct_off_o       (force_oct_off_o)
	);

	rdp_checker chk_i (
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.afi_rdata_en_i        (afi_rdata_en_i),
		.seq_read_latency_i    (seq_read_latency_i),
		.capture_dq_i          (capture_dq_i),
		.capture_valid_i       (capture_valid_i),
		.seq_read_fifo_reset_i (seq_read_fifo_reset_i),
		.afi_rdata_i           (afi_rdata_o),
		.afi_rdata_valid_i     (afi_rdata_valid_o),
		.rdata_underflow_i     (rdata_underflow_o),
		.force_oct_off_i       (force_oct_off_o),
		.tests_passed_o        (tests_passed),
		.tests_failed_o        (tests_failed)
	);

	initial begin
		pll_afi_clk = 1'b0;
		forever #(CLK_PERIOD / 2) pll_afi_clk = ~pll_afi_clk;
	end

	initial begin
		#(BUDGET_CYC * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the tests did not finish", BUDGET_CYC);
		$display("TB FAILED");
		$finish;
	end

	// Inputs change 2 ns after an edge and hold through the next one
	task automatic drive_cycle(input logic en, input rdp_pkg::rdp_group_mask_t strobe,
		input logic fifo_rst);
		afi_rdata_en_i        = en;
		capture_valid_i       = strobe;
		capture_dq_i          = rdp_pkg::rdp_dq_t'($random(seed));
		seq_read_fifo_reset_i = fifo_rst;
		@(posedge pll_afi_clk);
		#2;
	endtask

	task automatic idle(input int n);
		repeat (n) drive_cycle(1'b0, '0, 1'b0);
	endtask

	function automatic int rand_range(input int lo, input int hi);
		return lo + (($random(seed) & 32'h7fff_ffff) % (hi - lo + 1));
	endfunction

	// Sparse enables, each with its own bytes, at a fresh random latency
	task automatic run_latency();
		seq_read_latency_i = rdp_pkg::rdp_lat_t'(rand_range(1, 15));
		chk_i.begin_test($sformatf("latency_l%0d", seq_read_latency_i));
		repeat (LAT_READS) begin
			drive_cycle(1'b1, 2'b11, 1'b0);
			idle(rand_range(2, 4));
		end
		// Old enables must leave the whole shifter before the next test
		// moves the latency tap, or a longer tap would pop them again
		idle(`RDP_MAX_READ_LATENCY + 4);
		chk_i.end_test();
	endtask

	// Captures with independent strobes fill both groups before the reads
	task automatic data_batches(input int batches);
		int need;
		int got0;
		int got1;
		rdp_pkg::rdp_group_mask_t strobe;
		repeat (batches) begin
			need = rand_range(1, 4);
			got0 = 0;
			got1 = 0;
			while (got0 < need || got1 < need) begin
				strobe = rdp_pkg::rdp_group_mask_t'($random(seed));
				strobe[0] = strobe[0] && (got0 < need);
				strobe[1] = strobe[1] && (got1 < need);
				got0 += strobe[0];
				got1 += strobe[1];
				drive_cycle(1'b0, strobe, 1'b0);
			end
			repeat (need) begin
				drive_cycle(1'b1, '0, 1'b0);
				idle(rand_range(0, 2));
			end
			idle(seq_read_latency_i + 4);
		end
	endtask

	// Dense random enables; a short latency keeps the group FIFOs shallow
	task automatic run_termination();
		logic en;
		seq_read_latency_i = rdp_pkg::rdp_lat_t'(rand_range(1, 4));
		chk_i.begin_test("termination");
		repeat (40) begin
			en = $random(seed) & 1;
			drive_cycle(en, {2{en}}, 1'b0);
		end
		idle(seq_read_latency_i + 4);
		chk_i.end_test();
	endtask

	initial begin
		seed                  = 32'h97e6_0332;
		reset_n_afi_clk       = 1'b0;
		afi_rdata_en_i        = 1'b0;
		seq_read_latency_i    = rdp_pkg::rdp_lat_t'(1);
		capture_dq_i          = '0;
		capture_valid_i       = '0;
		seq_read_fifo_reset_i = 1'b0;
		chk_i.begin_test("reset_values");
		repeat (2) @(posedge pll_afi_clk);
		#2;
		reset_n_afi_clk = 1'b1;
		idle(3);
		chk_i.end_test();
		repeat (3) run_latency();
		chk_i.begin_test("data_order");
		data_batches(6);
		chk_i.end_test();
		run_termination();
		// Group 1 stays empty for this pop, and group 0 keeps a stale byte
		chk_i.begin_test("underflow_reset");
		drive_cycle(1'b0, '0, 1'b1);
		drive_cycle(1'b0, 2'b01, 1'b0);
		drive_cycle(1'b0, 2'b01, 1'b0);
		drive_cycle(1'b1, '0, 1'b0);
		idle(seq_read_latency_i + 4);
		drive_cycle(1'b0, '0, 1'b1);
		data_batches(2);
		chk_i.end_test();
		$display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hw
hw/rdp_pkg.sv
hw/rdp_latency_fifo.sv
hw/rdp_oct_ctrl.sv
hw/rdp_read_fifo.sv
hw/rdp_rdata_output.sv
hw/rdp_read_datapath.sv
verif/rdp_checker.sv
verif/tb_rdp.sv
